//--- source/l2_pkg.sv
/*
 * L2 cache shared definitions
 * Geometry, vector types, request structs and the controller states
 */

`default_nettype none

package l2_pkg;

	// Line and set geometry
	localparam int BEAT_W        = 64;
	localparam int LINE_BEATS    = 16;
	localparam int WAYS          = 4;
	localparam int SETS          = 32;
	localparam int LINE_LSB      = 7;
	localparam int SET_W         = 5;
	localparam int WAY_W         = 2;
	localparam int BEAT_IDX_W    = 4;
	localparam int TAG_W         = 20;
	// Memory refill is always a full line
	localparam int MEM_BURST_LEN = 15;

	typedef logic [31:0]           addr_t;
	typedef logic [BEAT_W-1:0]     beat_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [SET_W-1:0]      set_idx_t;
	typedef logic [WAY_W-1:0]      way_idx_t;
	typedef logic [WAYS-1:0]       way_mask_t;
	typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
	typedef logic [7:0]            burst_len_t;

	// First-level read request, len is beats minus one
	typedef struct packed {
		addr_t      addr;
		burst_len_t len;
	} rd_req_t;

	// One beat location in the data array
	typedef struct packed {
		way_idx_t  way;
		set_idx_t  set;
		beat_idx_t beat;
	} array_addr_t;

	typedef enum logic [2:0] {
		L2C_CFREE,
		L2C_CKTAG,
		L2C_FLASH,
		L2C_RSPIR,
		L2C_FENCE
	} l2_state_e;

endpackage

`default_nettype wire

//--- source/l2_ctrl.sv
/*
 * L2 cache controller
 * Sequences tag check, line refill, read response and fence
 */

`timescale 1ns/1ps
`default_nettype none

module l2_ctrl import l2_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic ar_valid,
	input  logic l2c_fence,
	input  logic hit,
	input  logic fill_done,
	input  logic rsp_done,
	output logic ar_ready,
	output logic fill_start,
	output logic rsp_start,
	output logic fence_clear
);

	l2_state_e state_q;
	l2_state_e state_d;
	logic      fence_pend_q;
	// Accept pulse, shared by ar_ready and rsp_start
	logic      grant_q;
	logic      fill_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			L2C_CFREE: begin
				// Fence wins over a waiting request
				if (fence_pend_q) begin
					state_d = L2C_FENCE;
				end else if (ar_valid) begin
					state_d = L2C_CKTAG;
				end
			end
			L2C_CKTAG: begin
				state_d = hit ? L2C_RSPIR : L2C_FLASH;
			end
			L2C_FLASH: begin
				// Check again once the line is in
				if (fill_done) begin
					state_d = L2C_CKTAG;
				end
			end
			L2C_RSPIR: begin
				if (rsp_done) begin
					state_d = L2C_CFREE;
				end
			end
			L2C_FENCE: begin
				state_d = L2C_CFREE;
			end
			default: begin
				state_d = L2C_CFREE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state_q      <= L2C_CFREE;
			fence_pend_q <= 1'b0;
			grant_q      <= 1'b0;
			fill_q       <= 1'b0;
		end else begin
			state_q      <= state_d;
			// Remember a fence until the FENCE state takes it
			fence_pend_q <= l2c_fence | (fence_pend_q & (state_q != L2C_FENCE));
			grant_q      <= (state_q == L2C_CKTAG) & hit;
			fill_q       <= (state_q == L2C_CKTAG) & ~hit;
		end
	end

	assign ar_ready    = grant_q;
	assign rsp_start   = grant_q;
	assign fill_start  = fill_q;
	assign fence_clear = (state_q == L2C_FENCE);

endmodule

`default_nettype wire

//--- source/l2_tag_store.sv
/*
 * L2 cache tag store
 * Tags and valid bits per way and set, hit detection and victim choice
 */

`timescale 1ns/1ps
`default_nettype none

module l2_tag_store import l2_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	input  addr_t    lookup_addr,
	input  logic     fill_start,
	input  logic     fence_clear,
	output logic     hit,
	output way_idx_t hit_way,
	output way_idx_t victim_way
);

	tag_t            tag_q [WAYS][SETS];
	logic [SETS-1:0] valid_q [WAYS];
	logic [15:0]     lfsr_q;
	set_idx_t        set_sel;
	tag_t            tag_sel;
	way_mask_t       hit_mask;
	way_mask_t       valid_mask;

	// Address split into tag and set
	assign set_sel = lookup_addr[LINE_LSB +: SET_W];
	assign tag_sel = lookup_addr[31 -: TAG_W];

	// Compare all ways of the selected set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			valid_mask[w] = valid_q[w][set_sel];
			hit_mask[w]   = valid_q[w][set_sel] & (tag_q[w][set_sel] == tag_sel);
		end
	end

	assign hit = |hit_mask;

	// Descending scan leaves the lowest matching way
	always_comb begin
		hit_way = '0;
		// Full set falls back to the pseudo-random way
		victim_way = way_idx_t'(lfsr_q[WAY_W-1:0]);
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (hit_mask[w]) begin
				hit_way = way_idx_t'(w);
			end
			if (!valid_mask[w]) begin
				victim_way = way_idx_t'(w);
			end
		end
	end

	// Free-running 16-bit LFSR, taps 16 14 13 11
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			lfsr_q <= 16'h0001;
		end else begin
			lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
		end
	end

	// Valid bits, fence clears every line
	always_ff @(posedge CLK) begin
		if (!rst_n || fence_clear) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else if (fill_start) begin
			valid_q[victim_way][set_sel] <= 1'b1;
		end
	end

	// New tag goes into the victim way
	always_ff @(posedge CLK) begin
		if (fill_start) begin
			tag_q[victim_way][set_sel] <= tag_sel;
		end
	end

endmodule

`default_nettype wire

//--- source/l2_refill.sv
/*
 * L2 cache line refill
 * Fetches one line from memory and writes it into the data array
 */

`timescale 1ns/1ps
`default_nettype none

module l2_refill import l2_pkg::*; (
	input  logic        CLK,
	input  logic        rst_n,
	input  logic        fill_start,
	input  addr_t       line_addr,
	input  way_idx_t    victim_way,
	output logic        mem_ar_valid,
	input  logic        mem_ar_ready,
	output addr_t       mem_ar_addr,
	input  logic        mem_r_valid,
	input  beat_t       mem_r_data,
	input  logic        mem_r_last,
	output logic        mem_r_ready,
	output logic        wr_en,
	output array_addr_t wr_loc,
	output beat_t       wr_data,
	output logic        fill_done
);

	addr_t     line_q;
	way_idx_t  way_q;
	beat_idx_t beat_q;
	logic      last_beat;

	// Accepted memory beat
	assign wr_en = mem_r_valid & mem_r_ready;
	// End on mem_r_last, or after a full line at the latest
	assign last_beat = mem_r_last | (beat_q == beat_idx_t'(MEM_BURST_LEN));

	// Line address and way, held for the whole burst
	always_ff @(posedge CLK) begin
		if (fill_start) begin
			line_q <= {line_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
			way_q  <= victim_way;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mem_ar_valid <= 1'b0;
			mem_r_ready  <= 1'b0;
			beat_q       <= '0;
		end else begin
			if (fill_start) begin
				mem_ar_valid <= 1'b1;
				beat_q       <= '0;
			end else if (mem_ar_valid && mem_ar_ready) begin
				// Address taken, open the data channel
				mem_ar_valid <= 1'b0;
				mem_r_ready  <= 1'b1;
			end else if (wr_en) begin
				beat_q <= beat_q + 1'b1;
				if (last_beat) begin
					mem_r_ready <= 1'b0;
				end
			end
		end
	end

	assign mem_ar_addr = line_q;
	assign wr_loc      = '{way: way_q, set: line_q[LINE_LSB +: SET_W], beat: beat_q};
	assign wr_data     = mem_r_data;
	assign fill_done   = wr_en & last_beat;

endmodule

`default_nettype wire

//--- source/l2_data_array.sv
/*
 * L2 cache data array
 * Line storage for all ways, written by the refill, read by the responder
 */

`timescale 1ns/1ps
`default_nettype none

module l2_data_array import l2_pkg::*; (
	input  logic        CLK,
	input  logic        wr_en,
	input  array_addr_t wr_loc,
	input  beat_t       wr_data,
	input  array_addr_t rd_loc,
	output beat_t       rd_data
);

	localparam int DEPTH = WAYS * SETS * LINE_BEATS;
	localparam int IDX_W = $bits(array_addr_t);

	beat_t            mem_q [DEPTH];
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	// Flat index is way, then set, then beat
	assign wr_idx = wr_loc;
	assign rd_idx = rd_loc;

	// One beat per cycle from the refill
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem_q[wr_idx] <= wr_data;
		end
	end

	// Asynchronous read
	assign rd_data = mem_q[rd_idx];

endmodule

`default_nettype wire

//--- source/l2_read_port.sv
/*
 * L2 cache first-level read responder
 * Streams an incrementing burst out of the data array
 */

`timescale 1ns/1ps
`default_nettype none

module l2_read_port import l2_pkg::*; (
	input  logic        CLK,
	input  logic        rst_n,
	input  logic        rsp_start,
	input  rd_req_t     req,
	input  way_idx_t    hit_way,
	output array_addr_t rd_loc,
	input  beat_t       rd_data,
	output logic        r_valid,
	input  logic        r_ready,
	output beat_t       r_data,
	output logic        r_last,
	output logic        rsp_done
);

	way_idx_t   way_q;
	set_idx_t   set_q;
	beat_idx_t  beat_q;
	burst_len_t len_q;
	burst_len_t cnt_q;
	logic       beat_hs;

	assign beat_hs = r_valid & r_ready;
	// Final beat once the count reaches len
	assign r_last  = r_valid & (cnt_q == len_q);

	// Burst origin, beat index steps per handshake
	always_ff @(posedge CLK) begin
		if (rsp_start) begin
			way_q  <= hit_way;
			set_q  <= req.addr[LINE_LSB +: SET_W];
			beat_q <= req.addr[LINE_LSB-1 -: BEAT_IDX_W];
			len_q  <= req.len;
		end else if (beat_hs) begin
			beat_q <= beat_q + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			r_valid <= 1'b0;
			cnt_q   <= '0;
		end else if (rsp_start) begin
			r_valid <= 1'b1;
			cnt_q   <= '0;
		end else if (beat_hs) begin
			if (r_last) begin
				r_valid <= 1'b0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Array is quiet during a response, so data holds under back-pressure
	assign rd_loc   = '{way: way_q, set: set_q, beat: beat_q};
	assign r_data   = rd_data;
	assign rsp_done = beat_hs & r_last;

endmodule

`default_nettype wire

//--- source/l2_cache.sv
/*
 * Read-only set-associative L2 cache
 * Controller, tag store, refill, data array and read responder
 */

`timescale 1ns/1ps
`default_nettype none

module l2_cache import l2_pkg::*; (
	input  logic    CLK,
	input  logic    rst_n,
	// First-level read port
	input  logic    ar_valid,
	input  rd_req_t ar_req,
	output logic    ar_ready,
	output logic    r_valid,
	output beat_t   r_data,
	output logic    r_last,
	input  logic    r_ready,
	// Memory read channels
	output logic    mem_ar_valid,
	input  logic    mem_ar_ready,
	output addr_t   mem_ar_addr,
	input  logic    mem_r_valid,
	input  beat_t   mem_r_data,
	input  logic    mem_r_last,
	output logic    mem_r_ready,
	input  logic    l2c_fence
);

	logic        hit;
	way_idx_t    hit_way;
	way_idx_t    victim_way;
	logic        fill_start;
	logic        fill_done;
	logic        rsp_start;
	logic        rsp_done;
	logic        fence_clear;
	logic        wr_en;
	array_addr_t wr_loc;
	beat_t       wr_data;
	array_addr_t rd_loc;
	beat_t       rd_data;

	l2_ctrl u_ctrl (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.ar_valid    (ar_valid),
		.l2c_fence   (l2c_fence),
		.hit         (hit),
		.fill_done   (fill_done),
		.rsp_done    (rsp_done),
		.ar_ready    (ar_ready),
		.fill_start  (fill_start),
		.rsp_start   (rsp_start),
		.fence_clear (fence_clear)
	);

	// Lookup runs on the held request address
	l2_tag_store u_tag_store (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.lookup_addr (ar_req.addr),
		.fill_start  (fill_start),
		.fence_clear (fence_clear),
		.hit         (hit),
		.hit_way     (hit_way),
		.victim_way  (victim_way)
	);

	l2_refill u_refill (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.fill_start   (fill_start),
		.line_addr    (ar_req.addr),
		.victim_way   (victim_way),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.mem_ar_addr  (mem_ar_addr),
		.mem_r_valid  (mem_r_valid),
		.mem_r_data   (mem_r_data),
		.mem_r_last   (mem_r_last),
		.mem_r_ready  (mem_r_ready),
		.wr_en        (wr_en),
		.wr_loc       (wr_loc),
		.wr_data      (wr_data),
		.fill_done    (fill_done)
	);

	l2_data_array u_data_array (
		.CLK     (CLK),
		.wr_en   (wr_en),
		.wr_loc  (wr_loc),
		.wr_data (wr_data),
		.rd_loc  (rd_loc),
		.rd_data (rd_data)
	);

	l2_read_port u_read_port (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.rsp_start (rsp_start),
		.req       (ar_req),
		.hit_way   (hit_way),
		.rd_loc    (rd_loc),
		.rd_data   (rd_data),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.r_data    (r_data),
		.r_last    (r_last),
		.rsp_done  (rsp_done)
	);

endmodule

`default_nettype wire

//--- sim/l2_checker.sv
/*
 * L2 cache checker
 * Watches the DUT ports, predicts every read beat and counts memory requests
 */

`timescale 1ns/1ps
`default_nettype none

module l2_checker import l2_pkg::*; (
	input  logic    CLK,
	input  logic    rst_n,
	input  logic    ar_valid,
	input  logic    ar_ready,
	input  rd_req_t ar_req,
	input  logic    r_valid,
	input  logic    r_ready,
	input  beat_t   r_data,
	input  logic    r_last,
	input  logic    mem_ar_valid,
	input  logic    mem_ar_ready,
	input  addr_t   mem_ar_addr,
	input  logic    mem_r_valid,
	input  logic    mem_r_last,
	input  logic    mem_r_ready,
	input  logic    fill_known,
	input  logic    fill_expected,
	input  logic    summary_req,
	output int      error_count,
	output int      test_count
);

	rd_req_t cur_req;
	logic    busy;
	logic    known_q;
	logic    expected_q;
	int      beat_cnt;
	int      fill_cnt;
	int      req_fills;
	int      mem_total;
	int      test_errors;
	logic    exp_last;
	addr_t   exp_line;
	// Expected mem_r_ready
	logic    rdy_exp;

	// Expected beat as a pattern of the beat's byte address
	function automatic beat_t expected_beat(addr_t base, int idx);
		addr_t a;
		a = base + addr_t'(8 * idx);
		return {a ^ 32'hc3a5_5a3c, a * 32'h9e37_79b9};
	endfunction

	task automatic value_error(string name, logic [63:0] expected, logic [63:0] actual);
		$display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, expected, actual);
		error_count++;
		test_errors++;
	endtask

	task automatic plain_error(string what);
		$display("%0t ns: %s", $time, what);
		error_count++;
		test_errors++;
	endtask

	initial begin
		error_count = 0;
		test_count  = 0;
		mem_total   = 0;
		fill_cnt    = 0;
		test_errors = 0;
		busy        = 1'b0;
	end

	always @(posedge CLK) begin
		if (rst_n) begin
			// Refill requests belong to the request still waiting for ar_ready
			if (mem_ar_valid && mem_ar_ready) begin
				fill_cnt++;
				mem_total++;
				// Line address with the low 7 bits cleared
				exp_line = ar_req.addr & 32'hffff_ff80;
				if (!ar_valid) begin
					plain_error("memory request issued with no read request pending");
				end else if (mem_ar_addr !== exp_line) begin
					value_error("mem_ar_addr", exp_line, mem_ar_addr);
				end
			end
			if (ar_valid && ar_ready) begin
				if (busy) begin
					plain_error("read request accepted while a burst was still running");
				end
				cur_req     = ar_req;
				known_q     = fill_known;
				expected_q  = fill_expected;
				req_fills   = fill_cnt;
				fill_cnt    = 0;
				beat_cnt    = 0;
				busy        = 1'b1;
			end
			if (r_valid && r_ready) begin
				if (!busy) begin
					plain_error("read beat returned with no request outstanding");
				end else begin
					exp_last = (beat_cnt == int'(cur_req.len));
					if (r_data !== expected_beat(cur_req.addr, beat_cnt)) begin
						value_error("r_data", expected_beat(cur_req.addr, beat_cnt), r_data);
					end
					if (r_last !== exp_last) begin
						value_error("r_last", exp_last, r_last);
					end
					if (exp_last) begin
						// Only checked where the line's cache state is known
						if (known_q && req_fills != int'(expected_q)) begin
							value_error("memory request count", expected_q, req_fills);
						end
						test_count++;
						$display("test %0d: addr %h len %0d, %0d beats, %0d memory requests, %s",
							test_count, cur_req.addr, cur_req.len, beat_cnt + 1, req_fills,
							(test_errors == 0) ? "ok" : "FAIL");
						test_errors = 0;
						busy        = 1'b0;
					end
					beat_cnt++;
				end
			end
		end
	end

	// mem_r_ready stays high from the address handshake to the last memory beat
	always @(posedge CLK) begin
		if (!rst_n) begin
			rdy_exp = 1'b0;
		end else begin
			if (mem_r_ready !== rdy_exp) begin
				value_error("mem_r_ready", rdy_exp, mem_r_ready);
			end
			if (mem_ar_valid && mem_ar_ready) begin
				rdy_exp = 1'b1;
			end else if (mem_r_valid && mem_r_ready && mem_r_last) begin
				rdy_exp = 1'b0;
			end
		end
	end

	always @(posedge summary_req) begin
		$display("%0d tests, %0d memory requests, %0d errors", test_count, mem_total, error_count);
	end

endmodule

`default_nettype wire

//--- sim/tb_l2_cache.sv
/*
 * L2 cache testbench
 * Clock, reset, memory model, read stimulus and watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache import l2_pkg::*; ();

	// Phases 1 and 2 read 8 lines twice each and phase 3 reads 12 lines twice
	localparam int NUM_TESTS       = 56;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (LINE_BEATS * 2 + 40);

	logic    CLK;
	logic    rst_n;
	logic    ar_valid;
	rd_req_t ar_req;
	logic    ar_ready;
	logic    r_valid;
	beat_t   r_data;
	logic    r_last;
	logic    r_ready;
	logic    mem_ar_valid;
	logic    mem_ar_ready;
	addr_t   mem_ar_addr;
	logic    mem_r_valid;
	beat_t   mem_r_data;
	logic    mem_r_last;
	logic    mem_r_ready;
	logic    l2c_fence;
	logic    fill_known;
	logic    fill_expected;
	logic    summary_req;
	int      error_count;
	int      test_count;
	int      seed = 32'h64cdfe54;
	int      stall_seed;
	// Memory model state
	logic    ar_taken;
	logic    beat_taken;
	addr_t   taken_addr;
	addr_t   mem_line;
	int      mem_beat;
	logic    mem_busy;
	tag_t    line_tag [8];
	tag_t    evict_tag [12];

	l2_cache UUT (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.ar_valid     (ar_valid),
		.ar_req       (ar_req),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r_data       (r_data),
		.r_last       (r_last),
		.r_ready      (r_ready),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.mem_ar_addr  (mem_ar_addr),
		.mem_r_valid  (mem_r_valid),
		.mem_r_data   (mem_r_data),
		.mem_r_last   (mem_r_last),
		.mem_r_ready  (mem_r_ready),
		.l2c_fence    (l2c_fence)
	);

	l2_checker u_checker (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.ar_req        (ar_req),
		.r_valid       (r_valid),
		.r_ready       (r_ready),
		.r_data        (r_data),
		.r_last        (r_last),
		.mem_ar_valid  (mem_ar_valid),
		.mem_ar_ready  (mem_ar_ready),
		.mem_ar_addr   (mem_ar_addr),
		.mem_r_valid   (mem_r_valid),
		.mem_r_last    (mem_r_last),
		.mem_r_ready   (mem_r_ready),
		.fill_known    (fill_known),
		.fill_expected (fill_expected),
		.summary_req   (summary_req),
		.error_count   (error_count),
		.test_count    (test_count)
	);

	// Memory contents as a pattern of the byte address
	function automatic beat_t mem_pattern(addr_t a);
		return {a ^ 32'hc3a5_5a3c, a * 32'h9e37_79b9};
	endfunction

	function automatic addr_t make_addr(tag_t tag, set_idx_t set, beat_idx_t beat);
		return {tag, set, beat, 3'b000};
	endfunction

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Handshakes seen at the rising edge for the memory model
	always @(posedge CLK) begin
		ar_taken   <= mem_ar_valid & mem_ar_ready;
		beat_taken <= mem_r_valid & mem_r_ready;
		if (mem_ar_valid && mem_ar_ready) begin
			taken_addr <= mem_ar_addr;
		end
	end

	// Memory model and first-level r_ready with random stalls
	initial begin : memory_model
		stall_seed   = seed ^ 32'h0f0f_0f0f;
		r_ready      = 1'b0;
		mem_ar_ready = 1'b0;
		mem_r_valid  = 1'b0;
		mem_r_data   = '0;
		mem_r_last   = 1'b0;
		mem_busy     = 1'b0;
		mem_beat     = 0;
		mem_line     = '0;
		@(posedge rst_n);
		forever begin
			@(negedge CLK);
			r_ready = ($random(stall_seed) & 3) != 0;
			if (ar_taken) begin
				mem_busy = 1'b1;
				mem_beat = 0;
				mem_line = taken_addr;
			end else if (beat_taken) begin
				mem_beat++;
				if (mem_beat == LINE_BEATS) begin
					mem_busy = 1'b0;
				end
			end
			mem_ar_ready = !mem_busy && mem_ar_valid && (($random(stall_seed) & 3) != 0);
			mem_r_valid  = mem_busy && (($random(stall_seed) & 3) != 0);
			mem_r_last   = mem_r_valid && (mem_beat == MEM_BURST_LEN);
			mem_r_data   = mem_pattern(mem_line + addr_t'(8 * mem_beat));
		end
	end

	task automatic issue_read(addr_t addr, burst_len_t len, logic known, logic expected);
		@(negedge CLK);
		ar_valid      = 1'b1;
		ar_req        = '{addr: addr, len: len};
		fill_known    = known;
		fill_expected = expected;
		// Request held until the cache takes it
		do begin
			@(posedge CLK);
		end while (!ar_ready);
		@(negedge CLK);
		ar_valid = 1'b0;
		// Final beat ends the test
		do begin
			@(posedge CLK);
		end while (!(r_valid && r_ready && r_last));
	endtask

	// Random start beat with the length kept inside the line
	task automatic read_random(tag_t tag, set_idx_t set, logic known, logic expected);
		beat_idx_t  beat;
		burst_len_t len;
		beat = beat_idx_t'($random(seed));
		len  = burst_len_t'($unsigned($random(seed)) % (LINE_BEATS - beat));
		issue_read(make_addr(tag, set, beat), len, known, expected);
	endtask

	task automatic pulse_fence();
		@(negedge CLK);
		l2c_fence = 1'b1;
		@(negedge CLK);
		l2c_fence = 1'b0;
	endtask

	initial begin : stimulus
		rst_n         = 1'b0;
		ar_valid      = 1'b0;
		ar_req        = '0;
		l2c_fence     = 1'b0;
		fill_known    = 1'b0;
		fill_expected = 1'b0;
		summary_req   = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		// Miss then hit on one line per set
		for (int i = 0; i < 8; i++) begin
			line_tag[i] = tag_t'($random(seed));
			read_random(line_tag[i], set_idx_t'(i), 1'b1, 1'b1);
			read_random(line_tag[i], set_idx_t'(i), 1'b1, 1'b0);
		end
		// Fence drops every line
		pulse_fence();
		for (int i = 0; i < 8; i++) begin
			read_random(line_tag[i], set_idx_t'(i), 1'b1, 1'b1);
			read_random(line_tag[i], set_idx_t'(i), 1'b1, 1'b0);
		end
		// Twelve lines fight over the four ways of set 20
		for (int i = 0; i < 12; i++) begin
			evict_tag[i] = tag_t'((i + 1) * 20'h0b3c5);
			read_random(evict_tag[i], set_idx_t'(20), 1'b0, 1'b0);
		end
		for (int i = 11; i >= 0; i--) begin
			read_random(evict_tag[i], set_idx_t'(20), 1'b0, 1'b0);
		end
		repeat (2) @(negedge CLK);
		summary_req = 1'b1;
		#1;
		if (test_count != NUM_TESTS) begin
			$display("Only %0d of %0d bursts completed", test_count, NUM_TESTS);
		end
		if (error_count == 0 && test_count == NUM_TESTS) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Bound on the whole run scaled by the number of tests
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout: the cache stopped answering after %0d cycles", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
source/l2_pkg.sv
source/l2_ctrl.sv
source/l2_tag_store.sv
source/l2_refill.sv
source/l2_data_array.sv
source/l2_read_port.sv
source/l2_cache.sv
sim/l2_checker.sv
sim/tb_l2_cache.sv

//--- Bender.yml
package:
  name: l2_cache

sources:
  - source/l2_pkg.sv
  - source/l2_ctrl.sv
  - source/l2_tag_store.sv
  - source/l2_refill.sv
  - source/l2_data_array.sv
  - source/l2_read_port.sv
  - source/l2_cache.sv
  - target: test
    files:
      - sim/l2_checker.sv
      - sim/tb_l2_cache.sv
